// File: sim.f
rtl/busPkg.sv
rtl/cpuPkg.sv
rtl/fetchStage.sv
rtl/decodeUnit.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/hazardUnit.sv
rtl/mipsCore.sv
dv/clockGen.sv
dv/coreTb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := coreTb
FILELIST  := sim.f
OBJDIR    := obj_dir
SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJDIR)

// File: dv/coreTb.sv
`timescale 1ns/10ps

module coreTb;
    logic            clk;
    logic            resetn;
    busPkg::ibusReq  ireq;
    busPkg::ibusResp iresp = '0;
    busPkg::dbusReq  dreq;
    busPkg::dbusResp dresp = '0;

    logic [31:0] prog[$];
    logic [31:0] dutMem[logic [29:0]];
    logic [31:0] refMem[logic [29:0]];
    logic [31:0] expAddr[$];
    logic [31:0] expData[$];
    int          expTest[$];
    int          sectionStart[5];
    int          testErr[5];
    string       testName[5] = '{"reset and first fetch", "ALU operations", "forwarding",
                                 "load-use and branch stalls", "branches and jumps"};
    logic [31:0] haltPc;
    logic [15:0] storeOff;
    integer      seed;
    int          seen = 0;
    int          fetchErr = 0;
    int          extraErr = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    clockGen clkGen_i (.clk(clk), .resetn(resetn));

    mipsCore dut_i (
        .clk(clk), .resetn(resetn), .ireq(ireq), .iresp(iresp), .dreq(dreq), .dresp(dresp)
    );

    // Words never written read back as a pattern of their own address
    function automatic logic [31:0] fillOf(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] memWord(input logic [31:0] addr);
        return dutMem.exists(addr[31:2]) ? dutMem[addr[31:2]] : fillOf(addr);
    endfunction

    function automatic logic [31:0] refWord(input logic [31:0] addr);
        return refMem.exists(addr[31:2]) ? refMem[addr[31:2]] : fillOf(addr);
    endfunction

    function automatic logic [31:0] addrOf(input int idx);
        return cpuPkg::RESET_PC + 32'(idx) * 32'd4;
    endfunction

    function automatic logic [31:0] rOp(input logic [5:0] fn, input logic [4:0] rd, rs, rt,
                                        input logic [4:0] sa);
        return {cpuPkg::OP_RTYPE, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] iOp(input logic [5:0] op, input logic [4:0] rs, rt,
                                        input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jOp(input logic [31:0] target);
        return {cpuPkg::OP_J, target[27:2]};
    endfunction

    task automatic put(input logic [31:0] w);
        prog.push_back(w);
    endtask

    task automatic loadConst(input logic [4:0] r, input logic [31:0] v);
        put(iOp(cpuPkg::OP_LUI, 5'd0, r, v[31:16]));
        put(iOp(cpuPkg::OP_ORI, r, r, v[15:0]));
    endtask

    // Every result lands in its own word above the data base held in r20
    task automatic storeOut(input logic [4:0] r);
        put(iOp(cpuPkg::OP_SW, 5'd20, r, storeOff));
        storeOff = storeOff + 16'd4;
    endtask

    // Branch, delay-slot store, a store a taken branch skips, then the target store
    task automatic branchCase(input logic [5:0] op, input logic [4:0] rs, rt);
        put(iOp(op, rs, rt, 16'd2));
        storeOut(5'd3);
        storeOut(5'd4);
        storeOut(5'd5);
    endtask

    task automatic buildProgram();
        logic [5:0]  fns[6] = '{cpuPkg::FN_ADDU, cpuPkg::FN_SUBU, cpuPkg::FN_AND,
                               cpuPkg::FN_OR, cpuPkg::FN_XOR, cpuPkg::FN_SLT};
        logic [5:0]  imOps[4] = '{cpuPkg::OP_ADDIU, cpuPkg::OP_ANDI, cpuPkg::OP_ORI,
                                 cpuPkg::OP_LUI};
        logic [31:0] a;
        storeOff = 16'd0;
        sectionStart[1] = 0;
        put(iOp(cpuPkg::OP_ORI, 5'd0, 5'd20, 16'h1000));
        for (int r = 1; r <= 8; r++) begin
            loadConst(5'(r), $random(seed));
        end
        foreach (fns[k]) begin
            put(rOp(fns[k], 5'd9, 5'(k + 1), 5'(8 - k), 5'd0));
            storeOut(5'd9);
        end
        put(rOp(cpuPkg::FN_SLT, 5'd9, 5'd8, 5'd1, 5'd0));
        storeOut(5'd9);
        put(rOp(cpuPkg::FN_SLL, 5'd9, 5'd0, 5'd7, 5'($random(seed))));
        storeOut(5'd9);
        foreach (imOps[k]) begin
            put(iOp(imOps[k], 5'(k + 2), 5'd10, 16'($random(seed))));
            storeOut(5'd10);
        end

        // Chains where each operand comes from the memory or the writeback stage
        sectionStart[2] = prog.size();
        put(rOp(cpuPkg::FN_ADDU, 5'd11, 5'd1, 5'd2, 5'd0));
        put(rOp(cpuPkg::FN_SUBU, 5'd12, 5'd11, 5'd3, 5'd0));
        put(rOp(cpuPkg::FN_XOR, 5'd13, 5'd11, 5'd12, 5'd0));
        put(rOp(cpuPkg::FN_OR, 5'd14, 5'd13, 5'd11, 5'd0));
        put(iOp(cpuPkg::OP_ADDIU, 5'd14, 5'd15, 16'($random(seed))));
        put(rOp(cpuPkg::FN_SLL, 5'd15, 5'd0, 5'd15, 5'd3));
        for (int r = 15; r >= 12; r--) begin
            storeOut(5'(r));
        end

        sectionStart[3] = prog.size();
        put(iOp(cpuPkg::OP_SW, 5'd20, 5'd1, 16'h0800));
        put(iOp(cpuPkg::OP_LW, 5'd20, 5'd16, 16'h0800));
        put(rOp(cpuPkg::FN_ADDU, 5'd17, 5'd16, 5'd2, 5'd0));
        storeOut(5'd17);
        put(iOp(cpuPkg::OP_LW, 5'd20, 5'd18, 16'h0900));
        storeOut(5'd18);
        put(rOp(cpuPkg::FN_ADDU, 5'd19, 5'd1, 5'd0, 5'd0));
        branchCase(cpuPkg::OP_BEQ, 5'd19, 5'd1);
        put(iOp(cpuPkg::OP_LW, 5'd20, 5'd21, 16'h0800));
        branchCase(cpuPkg::OP_BNE, 5'd21, 5'd1);

        sectionStart[4] = prog.size();
        branchCase(cpuPkg::OP_BEQ, 5'd1, 5'd1);
        branchCase(cpuPkg::OP_BEQ, 5'd1, 5'd2);
        branchCase(cpuPkg::OP_BNE, 5'd1, 5'd2);
        branchCase(cpuPkg::OP_BNE, 5'd1, 5'd1);
        put(jOp(addrOf(prog.size() + 3)));
        storeOut(5'd6);
        storeOut(5'd7);
        storeOut(5'd8);
        // The core parks in a jump to itself with a nop in the slot
        haltPc = addrOf(prog.size());
        put(jOp(haltPc));
        put(32'd0);

        for (int k = 0; k < prog.size(); k++) begin
            a = addrOf(k);
            dutMem[a[31:2]] = prog[k];
            refMem[a[31:2]] = prog[k];
        end
    endtask

    function automatic int sectionOf(input logic [31:0] pc);
        int idx;
        int t;
        idx = int'((pc - cpuPkg::RESET_PC) >> 2);
        t = 1;
        for (int k = 2; k < 5; k++) begin
            if (idx >= sectionStart[k]) begin
                t = k;
            end
        end
        return t;
    endfunction

    // ISA model with a delay slot; returns the number of instructions executed
    function automatic int runReference();
        logic [31:0] regs[32];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nnpc;
        logic [31:0] p4;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        int          steps;
        foreach (regs[k]) begin
            regs[k] = 32'd0;
        end
        pc = cpuPkg::RESET_PC;
        npc = pc + 32'd4;
        steps = 0;
        while (pc != haltPc && steps < 20000) begin
            ins = refWord(pc);
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            sx = {{16{ins[15]}}, ins[15:0]};
            p4 = pc + 32'd4;
            nnpc = npc + 32'd4;
            case (ins[31:26])
                cpuPkg::OP_RTYPE: case (ins[5:0])
                    cpuPkg::FN_ADDU: regs[ins[15:11]] = a + b;
                    cpuPkg::FN_SUBU: regs[ins[15:11]] = a - b;
                    cpuPkg::FN_AND:  regs[ins[15:11]] = a & b;
                    cpuPkg::FN_OR:   regs[ins[15:11]] = a | b;
                    cpuPkg::FN_XOR:  regs[ins[15:11]] = a ^ b;
                    cpuPkg::FN_SLT:  regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    cpuPkg::FN_SLL:  regs[ins[15:11]] = b << ins[10:6];
                    default: ;
                endcase
                cpuPkg::OP_ADDIU: regs[ins[20:16]] = a + sx;
                cpuPkg::OP_ANDI:  regs[ins[20:16]] = a & {16'd0, ins[15:0]};
                cpuPkg::OP_ORI:   regs[ins[20:16]] = a | {16'd0, ins[15:0]};
                cpuPkg::OP_LUI:   regs[ins[20:16]] = {ins[15:0], 16'd0};
                cpuPkg::OP_LW:    regs[ins[20:16]] = refWord(a + sx);
                cpuPkg::OP_SW: begin
                    refMem[(a + sx) >> 2] = b;
                    expAddr.push_back(a + sx);
                    expData.push_back(b);
                    expTest.push_back(sectionOf(pc));
                end
                cpuPkg::OP_BEQ: nnpc = (a == b) ? p4 + (sx << 2) : nnpc;
                cpuPkg::OP_BNE: nnpc = (a != b) ? p4 + (sx << 2) : nnpc;
                cpuPkg::OP_J:   nnpc = {p4[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            regs[0] = 32'd0;
            pc = npc;
            npc = nnpc;
            steps++;
        end
        return steps;
    endfunction

    task automatic checkFetch(input busPkg::ibusReq got, input logic [31:0] addr);
        if (got.valid !== 1'b1) begin
            $display("FAIL ireq.valid: got %h, expected 1", got.valid);
            fetchErr++;
        end
        if (got.addr !== addr) begin
            $display("FAIL ireq.addr: got %h, expected %h", got.addr, addr);
            fetchErr++;
        end
    endtask

    task automatic checkStore(input busPkg::dbusReq got, input int k);
        if (got.addr !== expAddr[k]) begin
            $display("FAIL dreq.addr (store %0d): got %h, expected %h", k, got.addr, expAddr[k]);
            testErr[expTest[k]]++;
        end
        if (got.data !== expData[k]) begin
            $display("FAIL dreq.data (store %0d): got %h, expected %h", k, got.data, expData[k]);
            testErr[expTest[k]]++;
        end
    endtask

    task automatic reportTest(input int t, input int errs);
        testsRun++;
        if (errs == 0) begin
            $display("test %0d %s: ok", t, testName[t]);
        end else begin
            testsFailed++;
            $display("test %0d %s: %0d errors", t, testName[t], errs);
        end
    endtask

    // Zero-wait memory, answered on the falling edge while the requests are stable
    always @(negedge clk) begin
        if (dreq.valid === 1'b1 && dreq.write === 1'b1) begin
            dutMem[dreq.addr[31:2]] = dreq.data;
        end
        iresp.data <= memWord(ireq.addr);
        dresp.data <= memWord(dreq.addr);
    end

    always @(negedge clk) begin
        if (dreq.valid === 1'b1 && dreq.write !== 1'b1 && seen == 0) begin
            $display("ERROR: data bus access at %h before the first store", dreq.addr);
            testErr[0]++;
        end else if (dreq.valid === 1'b1 && dreq.write === 1'b1) begin
            if (seen >= expAddr.size()) begin
                $display("ERROR: store to %h with data %h after the last expected store",
                         dreq.addr, dreq.data);
                extraErr++;
            end else begin
                if (seen == 0) begin
                    reportTest(0, testErr[0] + fetchErr);
                end
                checkStore(dreq, seen);
                if (seen + 1 == expAddr.size() || expTest[seen + 1] != expTest[seen]) begin
                    reportTest(expTest[seen], testErr[expTest[seen]]);
                end
                seen++;
            end
        end
    end

    initial begin
        int limit;
        int cycles;
        int totalErr;
        seed = 32'h4100;
        buildProgram();
        limit = 8 * runReference() + 200;
        @(posedge resetn);
        checkFetch(ireq, cpuPkg::RESET_PC);
        cycles = 0;
        while (seen < expAddr.size() && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (seen < expAddr.size()) begin
            $display("ERROR: the program did not finish within %0d cycles (%0d of %0d stores seen)",
                     limit, seen, expAddr.size());
            $display("*** TEST FAILED ***");
        end else begin
            // Long enough for a wrong-path store to leave the pipeline
            repeat (10) @(posedge clk);
            totalErr = fetchErr + extraErr;
            foreach (testErr[k]) begin
                totalErr += testErr[k];
            end
            $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                     testsRun, testsRun - testsFailed, testsFailed, totalErr);
            if (totalErr == 0 && testsRun == 5) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
        end
        $finish;
    end

endmodule

// File: dv/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic resetn
);
    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset is held for 16 cycles and released on a falling edge
    initial begin
        resetn = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

// File: rtl/mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
    input  logic            clk,
    input  logic            resetn,
    output busPkg::ibusReq  ireq,
    input  busPkg::ibusResp iresp,
    output busPkg::dbusReq  dreq,
    input  busPkg::dbusResp dresp
);
    logic [31:0]       pcF;
    logic [31:0]       pcD;
    cpuPkg::instrWord  instrD;
    cpuPkg::decExStage decEx;
    cpuPkg::exMemStage exMem;
    cpuPkg::exMemStage memView;
    cpuPkg::memWbStage memWb;

    cpuPkg::ctrlWord   ctrlD;
    logic [4:0]        rsD;
    logic [4:0]        rtD;
    logic [4:0]        destD;
    logic [4:0]        shamtD;
    logic [31:0]       immD;
    logic              branchTaken;
    logic [31:0]       branchTarget;
    logic              branchUse;
    logic [31:0]       vsD;
    logic [31:0]       vtD;
    logic [31:0]       vsFwdD;
    logic [31:0]       vtFwdD;
    logic [31:0]       vsFwdE;
    logic [31:0]       vtFwdE;
    logic              stall;
    logic [31:0]       aluOutE;
    logic [31:0]       storeDataE;
    logic [31:0]       memResult;

    fetchStage fetch_i (
        .clk(clk), .resetn(resetn), .stall(stall),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .pc(pcF), .ireq(ireq)
    );

    decodeUnit decode_i (
        .instr(instrD), .pc(pcD), .vs(vsFwdD), .vt(vtFwdD),
        .ctrl(ctrlD), .rs(rsD), .rt(rtD), .dest(destD), .shamt(shamtD), .imm(immD),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    regFile regs_i (
        .clk(clk), .ra1(rsD), .ra2(rtD),
        .we(memWb.ctrl.regWrite), .wa(memWb.dest), .wd(memWb.result),
        .rd1(vsD), .rd2(vtD)
    );

    assign branchUse = instrD.i.op == cpuPkg::OP_BEQ || instrD.i.op == cpuPkg::OP_BNE;

    // Load data is already back in the memory stage, so forwarding sees the final value
    assign memResult = exMem.ctrl.memRead ? dresp.data : exMem.aluOut;
    always_comb begin
        memView        = exMem;
        memView.aluOut = memResult;
    end

    hazardUnit hazard_i (
        .clk(clk), .resetn(resetn), .rsD(rsD), .rtD(rtD), .branchUse(branchUse),
        .exStage(decEx), .memStage(memView), .wbStage(memWb),
        .vsD(vsD), .vtD(vtD),
        .vsFwdD(vsFwdD), .vtFwdD(vtFwdD), .vsFwdE(vsFwdE), .vtFwdE(vtFwdE),
        .stall(stall)
    );

    aluUnit alu_i (
        .stage(decEx), .vs(vsFwdE), .vt(vtFwdE),
        .aluOut(aluOutE), .storeData(storeDataE)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pcD    <= '0;
            instrD <= '0;
            decEx  <= '0;
            exMem  <= '0;
            memWb  <= '0;
        end else begin
            if (stall) begin
                decEx <= '0;
            end else begin
                pcD          <= pcF;
                instrD       <= iresp.data;
                decEx.ctrl   <= ctrlD;
                decEx.pc     <= pcD;
                decEx.rs     <= rsD;
                decEx.rt     <= rtD;
                decEx.dest   <= destD;
                decEx.shamt  <= shamtD;
                decEx.vs     <= vsFwdD;
                decEx.vt     <= vtFwdD;
                decEx.imm    <= immD;
            end
            exMem.ctrl      <= decEx.ctrl;
            exMem.dest      <= decEx.dest;
            exMem.aluOut    <= aluOutE;
            exMem.storeData <= storeDataE;
            memWb.ctrl      <= exMem.ctrl;
            memWb.dest      <= exMem.dest;
            memWb.result    <= memResult;
        end
    end

    assign dreq.valid = exMem.ctrl.memRead || exMem.ctrl.memWrite;
    assign dreq.write = exMem.ctrl.memWrite;
    assign dreq.addr  = exMem.aluOut;
    assign dreq.data  = exMem.storeData;

    // Only whole-word loads and stores exist
    assert property (@(posedge clk) disable iff (!resetn) dreq.valid |-> dreq.addr[1:0] == 2'b00);

endmodule

// File: rtl/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    input  logic              clk,
    input  logic              resetn,
    input  logic [4:0]        rsD,
    input  logic [4:0]        rtD,
    input  logic              branchUse,
    input  cpuPkg::decExStage exStage,
    input  cpuPkg::exMemStage memStage,
    input  cpuPkg::memWbStage wbStage,
    input  logic [31:0]       vsD,
    input  logic [31:0]       vtD,
    output logic [31:0]       vsFwdD,
    output logic [31:0]       vtFwdD,
    output logic [31:0]       vsFwdE,
    output logic [31:0]       vtFwdE,
    output logic              stall
);
    cpuPkg::fwdSel selSD;
    cpuPkg::fwdSel selTD;
    cpuPkg::fwdSel selSE;
    cpuPkg::fwdSel selTE;
    logic          loadUse;
    logic          branchWait;

    // The younger producer in memory wins over writeback
    function automatic cpuPkg::fwdSel pickSrc(input logic [4:0] r,
                                              input cpuPkg::exMemStage m,
                                              input cpuPkg::memWbStage w);
        if (r == 5'd0) begin
            return cpuPkg::FWD_NONE;
        end else if (m.ctrl.regWrite && m.dest == r) begin
            return cpuPkg::FWD_MEM;
        end else if (w.ctrl.regWrite && w.dest == r) begin
            return cpuPkg::FWD_WB;
        end
        return cpuPkg::FWD_NONE;
    endfunction

    function automatic logic [31:0] applyFwd(input cpuPkg::fwdSel sel, input logic [31:0] raw,
                                             input logic [31:0] memVal,
                                             input logic [31:0] wbVal);
        case (sel)
            cpuPkg::FWD_MEM: return memVal;
            cpuPkg::FWD_WB:  return wbVal;
            default:         return raw;
        endcase
    endfunction

    always_comb begin
        selSD  = pickSrc(rsD, memStage, wbStage);
        selTD  = pickSrc(rtD, memStage, wbStage);
        selSE  = pickSrc(exStage.rs, memStage, wbStage);
        selTE  = pickSrc(exStage.rt, memStage, wbStage);
        vsFwdD = applyFwd(selSD, vsD, memStage.aluOut, wbStage.result);
        vtFwdD = applyFwd(selTD, vtD, memStage.aluOut, wbStage.result);
        vsFwdE = applyFwd(selSE, exStage.vs, memStage.aluOut, wbStage.result);
        vtFwdE = applyFwd(selTE, exStage.vt, memStage.aluOut, wbStage.result);
    end

    assign loadUse = exStage.ctrl.memRead && exStage.dest != 5'd0 &&
                     (exStage.dest == rsD || exStage.dest == rtD);
    assign branchWait = branchUse && exStage.ctrl.regWrite && exStage.dest != 5'd0 &&
                        (exStage.dest == rsD || exStage.dest == rtD);
    assign stall = loadUse || branchWait;

    // The bubble put into execute by the core clears the cause within one cycle
    assert property (@(posedge clk) disable iff (!resetn) stall |=> !stall);

endmodule

// File: rtl/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
    input  cpuPkg::decExStage stage,
    input  logic [31:0]       vs,
    input  logic [31:0]       vt,
    output logic [31:0]       aluOut,
    output logic [31:0]       storeData
);
    logic [31:0] opB;

    assign opB = stage.ctrl.aluSrcImm ? stage.imm : vt;

    always_comb begin
        case (stage.ctrl.alu)
            cpuPkg::ALU_ADD: aluOut = vs + opB;
            cpuPkg::ALU_SUB: aluOut = vs - opB;
            cpuPkg::ALU_AND: aluOut = vs & opB;
            cpuPkg::ALU_OR:  aluOut = vs | opB;
            cpuPkg::ALU_XOR: aluOut = vs ^ opB;
            cpuPkg::ALU_SLT: aluOut = {31'd0, $signed(vs) < $signed(opB)};
            // Shift amount comes from the instruction, not from rs
            cpuPkg::ALU_SLL: aluOut = vt << stage.shamt;
            cpuPkg::ALU_LUI: aluOut = {stage.imm[15:0], 16'd0};
            default:         aluOut = 32'd0;
        endcase
    end

    assign storeData = vt;

endmodule

// File: rtl/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic        clk,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // A same-cycle write is visible to decode without waiting a cycle
    always_comb begin
        if (ra1 == 5'd0) begin
            rd1 = 32'd0;
        end else if (we && wa == ra1) begin
            rd1 = wd;
        end else begin
            rd1 = regs[ra1];
        end
        if (ra2 == 5'd0) begin
            rd2 = 32'd0;
        end else if (we && wa == ra2) begin
            rd2 = wd;
        end else begin
            rd2 = regs[ra2];
        end
    end

endmodule

// File: rtl/decodeUnit.sv
`timescale 1ns/10ps

module decodeUnit (
    input  cpuPkg::instrWord instr,
    input  logic [31:0]      pc,
    input  logic [31:0]      vs,
    input  logic [31:0]      vt,
    output cpuPkg::ctrlWord  ctrl,
    output logic [4:0]       rs,
    output logic [4:0]       rt,
    output logic [4:0]       dest,
    output logic [4:0]       shamt,
    output logic [31:0]      imm,
    output logic             branchTaken,
    output logic [31:0]      branchTarget
);
    logic [31:0] pcPlus4;
    logic [31:0] immSext;
    logic [25:0] jumpIndex;

    function automatic cpuPkg::ctrlWord ctrlOf(input logic wr, input logic ld,
                                              input logic st, input logic useImm,
                                              input cpuPkg::aluOp op);
        cpuPkg::ctrlWord c;
        c.regWrite  = wr;
        c.memRead   = ld;
        c.memWrite  = st;
        c.aluSrcImm = useImm;
        c.alu       = op;
        return c;
    endfunction

    assign pcPlus4   = pc + 32'd4;
    assign immSext   = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign jumpIndex = {instr.r.rs, instr.r.rt, instr.r.rd, instr.r.shamt, instr.r.funct};
    assign rs        = instr.r.rs;
    assign rt        = instr.r.rt;
    assign shamt     = instr.r.shamt;

    // Unknown opcodes and functs fall out as a zero control word
    always_comb begin
        ctrl = '0;
        dest = instr.i.rt;
        imm  = immSext;
        case (instr.i.op)
            cpuPkg::OP_RTYPE: begin
                dest = instr.r.rd;
                case (instr.r.funct)
                    cpuPkg::FN_ADDU: ctrl = ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, cpuPkg::ALU_ADD);
                    cpuPkg::FN_SUBU: ctrl = ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, cpuPkg::ALU_SUB);
                    cpuPkg::FN_AND:  ctrl = ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, cpuPkg::ALU_AND);
                    cpuPkg::FN_OR:   ctrl = ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, cpuPkg::ALU_OR);
                    cpuPkg::FN_XOR:  ctrl = ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, cpuPkg::ALU_XOR);
                    cpuPkg::FN_SLT:  ctrl = ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, cpuPkg::ALU_SLT);
                    cpuPkg::FN_SLL:  ctrl = ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, cpuPkg::ALU_SLL);
                    default:         ctrl = '0;
                endcase
            end
            cpuPkg::OP_ADDIU: ctrl = ctrlOf(1'b1, 1'b0, 1'b0, 1'b1, cpuPkg::ALU_ADD);
            cpuPkg::OP_ANDI: begin
                ctrl = ctrlOf(1'b1, 1'b0, 1'b0, 1'b1, cpuPkg::ALU_AND);
                imm  = {16'b0, instr.i.imm};
            end
            cpuPkg::OP_ORI: begin
                ctrl = ctrlOf(1'b1, 1'b0, 1'b0, 1'b1, cpuPkg::ALU_OR);
                imm  = {16'b0, instr.i.imm};
            end
            cpuPkg::OP_LUI: ctrl = ctrlOf(1'b1, 1'b0, 1'b0, 1'b1, cpuPkg::ALU_LUI);
            cpuPkg::OP_LW:  ctrl = ctrlOf(1'b1, 1'b1, 1'b0, 1'b1, cpuPkg::ALU_ADD);
            cpuPkg::OP_SW:  ctrl = ctrlOf(1'b0, 1'b0, 1'b1, 1'b1, cpuPkg::ALU_ADD);
            default:        ctrl = '0;
        endcase
    end

    // Targets are relative to the delay slot address
    always_comb begin
        branchTaken  = 1'b0;
        branchTarget = pcPlus4 + {immSext[29:0], 2'b00};
        case (instr.i.op)
            cpuPkg::OP_BEQ: branchTaken = (vs == vt);
            cpuPkg::OP_BNE: branchTaken = (vs != vt);
            cpuPkg::OP_J: begin
                branchTaken  = 1'b1;
                branchTarget = {pcPlus4[31:28], jumpIndex, 2'b00};
            end
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

// File: rtl/fetchStage.sv
`timescale 1ns/10ps

module fetchStage (
    input  logic           clk,
    input  logic           resetn,
    input  logic           stall,
    input  logic           branchTaken,
    input  logic [31:0]    branchTarget,
    output logic [31:0]    pc,
    output busPkg::ibusReq ireq
);
    logic [31:0] pcNext;

    // The branch sits in decode while its delay slot is fetched here,
    // so the redirect lands on the instruction after the slot
    always_comb begin
        if (stall) begin
            pcNext = pc;
        end else if (branchTaken) begin
            pcNext = branchTarget;
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= cpuPkg::RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    assign ireq.valid = 1'b1;
    assign ireq.addr  = pc;

    assert property (@(posedge clk) disable iff (!resetn) ireq.addr[1:0] == 2'b00);

endmodule

// File: rtl/cpuPkg.sv
package cpuPkg;

    localparam logic [31:0] RESET_PC = 32'hbfc0_0000;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFields;

    // Same word seen as R-type or I-type
    typedef union packed {
        rFields r;
        iFields i;
    } instrWord;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } aluOp;

    typedef enum logic [1:0] {
        FWD_NONE, FWD_MEM, FWD_WB
    } fwdSel;

    // An all-zero control word is a bubble
    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic aluSrcImm;
        aluOp alu;
    } ctrlWord;

    typedef struct packed {
        ctrlWord     ctrl;
        logic [31:0] pc;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [4:0]  shamt;
        logic [31:0] vs;
        logic [31:0] vt;
        logic [31:0] imm;
    } decExStage;

    typedef struct packed {
        ctrlWord     ctrl;
        logic [4:0]  dest;
        logic [31:0] aluOut;
        logic [31:0] storeData;
    } exMemStage;

    typedef struct packed {
        ctrlWord     ctrl;
        logic [4:0]  dest;
        logic [31:0] result;
    } memWbStage;

endpackage

// File: rtl/busPkg.sv
package busPkg;

    // Instruction fetch request, one word per cycle
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } ibusReq;

    // The memory answers in the same cycle as the request
    typedef struct packed {
        logic [31:0] data;
    } ibusResp;

    // Data request; write selects a store, otherwise a load
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] data;
    } dbusReq;

    // Load data, valid in the cycle of the request
    typedef struct packed {
        logic [31:0] data;
    } dbusResp;

endpackage
